/* Makefile */
TOP = tb_packet_switch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f verilog.f --top-module packet_switch

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) +verilator+error+limit+10 > sim.log 2>&1
	cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/buffer_manager.sv */
module buffer_manager
    import switch_pkg::*;
#(
    parameter int PORTS   = 4,
    parameter int DEPTH   = 64,
    parameter int MAX_PKT = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  wr_word_t               wr_word,
    input  deq_req_t               deq_req,
    output rd_word_t               rd_word,
    output logic [PORTS*PRIOS-1:0] nonempty,
    output logic                   full
);

    localparam int AW = $clog2(DEPTH);
    localparam int QN = PORTS * PRIOS;
    localparam int QW = $clog2(QN);

    // word storage, last flag on top of the data
    logic [DATA_W:0] data_mem [DEPTH];
    addr_t           link_mem [DEPTH];

    // free address ring
    addr_t         free_fifo [DEPTH];
    logic [AW-1:0] fl_rd;
    logic [AW-1:0] fl_wr;
    logic [AW:0]   free_cnt;
    logic [AW:0]   free_cnt_nxt;

    // packet being written
    addr_t wr_addr;
    addr_t prev_addr;
    addr_t pkt_head;

    // deferred append of a finished packet
    logic          enq_vld;
    logic [QW-1:0] enq_q;
    addr_t         enq_head;
    addr_t         enq_tail;

    // queue table
    addr_t       q_head [QN];
    addr_t       q_tail [QN];
    logic [AW:0] q_cnt  [QN];

    // read stream
    logic          rd_act;
    addr_t         rd_addr;
    logic [QW-1:0] rd_q;
    logic [QW-1:0] deq_q;
    logic          rd_end;
    logic          same_q;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic logic [QW-1:0] q_idx(input logic [PORT_W-1:0] port,
                                            input logic [PRIO_W-1:0] prio);
        return QW'(int'(port) * PRIOS + int'(prio));
    endfunction

    assign wr_addr      = free_fifo[fl_rd];
    assign deq_q        = q_idx(deq_req.port, deq_req.prio);
    assign rd_end       = rd_act && data_mem[rd_addr[AW-1:0]][DATA_W];
    assign same_q       = enq_vld && rd_end && (enq_q == rd_q);
    assign free_cnt_nxt = free_cnt - (AW+1)'(wr_word.vld) + (AW+1)'(rd_act);

    always_ff @(posedge clk) begin
        if (wr_word.vld) begin
            data_mem[wr_addr[AW-1:0]] <= {wr_word.last, wr_word.data};
        end
        // an append always lands before the next packet's second word
        if (enq_vld && q_cnt[enq_q] != '0) begin
            link_mem[q_tail[enq_q][AW-1:0]] <= enq_head;
        end else if (wr_word.vld && !wr_word.first) begin
            link_mem[prev_addr[AW-1:0]] <= wr_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_word.vld) begin
            prev_addr <= wr_addr;
        end
        if (wr_word.vld && wr_word.first) begin
            pkt_head <= wr_addr;
        end
        // a packet has at least two words, so the head is latched by its last word
        enq_head <= pkt_head;
        enq_tail <= wr_addr;
        enq_q    <= q_idx(wr_word.port, wr_word.prio);
        if (!rst_n) begin
            enq_vld <= 1'b0;
        end else begin
            enq_vld <= wr_word.vld && wr_word.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                free_fifo[i] <= addr_t'(i);
            end
            fl_rd    <= '0;
            fl_wr    <= '0;
            free_cnt <= (AW+1)'(DEPTH);
            full     <= 1'b0;
        end else begin
            if (wr_word.vld) begin
                fl_rd <= ptr_inc(fl_rd);
            end
            // every word read goes back to the ring
            if (rd_act) begin
                free_fifo[fl_wr] <= rd_addr;
                fl_wr            <= ptr_inc(fl_wr);
            end
            free_cnt <= free_cnt_nxt;
            full     <= free_cnt_nxt < (AW+1)'(MAX_PKT);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_end) begin
            q_head[rd_q] <= link_mem[rd_addr[AW-1:0]];
        end
        if (enq_vld) begin
            q_tail[enq_q] <= enq_tail;
            // last packet leaving as a new one arrives, so its link is not there yet
            if (q_cnt[enq_q] == '0 || (same_q && q_cnt[enq_q] == 1)) begin
                q_head[enq_q] <= enq_head;
            end
        end
        if (!rst_n) begin
            for (int q = 0; q < QN; q++) begin
                q_cnt[q] <= '0;
            end
        end else begin
            if (rd_end && !same_q) begin
                q_cnt[rd_q] <= q_cnt[rd_q] - 1'b1;
            end
            if (enq_vld && !same_q) begin
                q_cnt[enq_q] <= q_cnt[enq_q] + 1'b1;
            end
        end
    end

    always_comb begin
        for (int q = 0; q < QN; q++) begin
            nonempty[q] = q_cnt[q] != '0;
        end
    end

    always_ff @(posedge clk) begin
        {rd_word.last, rd_word.data} <= data_mem[rd_addr[AW-1:0]];
        if (deq_req.vld) begin
            rd_addr <= q_head[deq_q];
            rd_q    <= deq_q;
        end else if (rd_act) begin
            rd_addr <= link_mem[rd_addr[AW-1:0]];
        end
        if (!rst_n) begin
            rd_act      <= 1'b0;
            rd_word.vld <= 1'b0;
        end else begin
            rd_word.vld <= rd_act;
            if (deq_req.vld) begin
                rd_act <= 1'b1;
            end else if (rd_end) begin
                rd_act <= 1'b0;
            end
        end
    end

endmodule

/* rtl/egress_result.sv */
module egress_result
    import switch_pkg::*;
#(
    parameter int PORTS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [PORTS-1:0]       ready,
    input  logic [PORTS*PRIOS-1:0] nonempty,
    input  rd_word_t               rd_word,
    output deq_req_t               deq_req,
    output logic [PORTS-1:0]       rd_sop,
    output logic [PORTS-1:0]       rd_vld,
    output logic [PORTS-1:0]       rd_eop,
    output data_t [PORTS-1:0]      rd_data
);

    logic [PORTS-1:0]  pending;
    logic [PORTS-1:0]  cand;
    logic [PORTS-1:0]  sel_mask;
    logic              busy;
    // last served port, also the round-robin pointer
    logic [PORT_W-1:0] cur_port;
    logic              sel_vld;
    logic [PORT_W-1:0] sel_port;
    logic [PRIO_W-1:0] sel_prio;
    logic              issue;

    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            cand[p] = pending[p] && (nonempty[p*PRIOS +: PRIOS] != '0);
        end
    end

    // first candidate after the last served port
    always_comb begin
        int p;
        sel_vld  = 1'b0;
        sel_port = '0;
        for (int i = 1; i <= PORTS; i++) begin
            p = int'(cur_port) + i;
            if (p >= PORTS) begin
                p = p - PORTS;
            end
            if (!sel_vld && cand[p]) begin
                sel_vld  = 1'b1;
                sel_port = PORT_W'(p);
            end
        end
    end

    // strict priority, highest nonempty queue wins
    always_comb begin
        sel_prio = '0;
        for (int k = 0; k < PRIOS; k++) begin
            if (nonempty[int'(sel_port) * PRIOS + k]) begin
                sel_prio = PRIO_W'(k);
            end
        end
    end

    assign issue    = !busy && sel_vld;
    assign sel_mask = issue ? (PORTS'(1) << sel_port) : '0;

    always_ff @(posedge clk) begin
        deq_req.port <= sel_port;
        deq_req.prio <= sel_prio;
        if (!rst_n) begin
            pending     <= '0;
            busy        <= 1'b0;
            cur_port    <= PORT_W'(PORTS - 1);
            rd_sop      <= '0;
            deq_req.vld <= 1'b0;
        end else begin
            // a ready in the serving cycle stays pending for the next packet
            pending     <= (pending & ~sel_mask) | ready;
            rd_sop      <= sel_mask;
            deq_req.vld <= issue;
            if (issue) begin
                busy     <= 1'b1;
                cur_port <= sel_port;
            end else if (rd_word.vld && rd_word.last) begin
                busy <= 1'b0;
            end
        end
    end

    // stream goes to the served port only
    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            rd_vld[p]  = rd_word.vld && (cur_port == PORT_W'(p));
            rd_eop[p]  = rd_word.vld && rd_word.last && (cur_port == PORT_W'(p));
            rd_data[p] = (cur_port == PORT_W'(p)) ? rd_word.data : '0;
        end
    end

endmodule

/* rtl/ingress_decode.sv */
module ingress_decode
    import switch_pkg::*;
#(
    parameter int PORTS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [PORTS-1:0]   wr_sop,
    input  logic [PORTS-1:0]   wr_vld,
    input  logic [PORTS-1:0]   wr_eop,
    input  data_t [PORTS-1:0]  wr_data,
    input  logic               full,
    output logic [PORTS-1:0]   pause,
    output wr_word_t           wr_word
);

    localparam int PW = (PORTS > 1) ? $clog2(PORTS) : 1;

    // port currently offered the write slot
    logic [PW-1:0]     ptr;
    logic [PW-1:0]     ptr_nxt;
    logic              recv;
    logic              start;
    logic              take;
    logic [PORT_W-1:0] hdr_port;
    logic [PRIO_W-1:0] hdr_prio;

    assign ptr_nxt = (ptr == PW'(PORTS - 1)) ? '0 : ptr + 1'b1;

    // sop only counts on the port whose pause bit is low
    assign start = !pause[ptr] && wr_sop[ptr] && wr_vld[ptr];
    assign take  = (start || recv) && wr_vld[ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr   <= '0;
            pause <= '1;
            recv  <= 1'b0;
        end else begin
            if (take) begin
                recv <= !wr_eop[ptr];
            end
            // slot stays locked until the eop word has left wr_word,
            // so full is up to date when the next slot opens
            if (start || recv || wr_word.vld || full) begin
                pause <= '1;
            end else begin
                ptr   <= ptr_nxt;
                pause <= ~(PORTS'(1) << ptr_nxt);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_port <= wr_data[ptr][PORT_W-1:0];
            hdr_prio <= wr_data[ptr][PORT_W +: PRIO_W];
        end
        wr_word.data  <= wr_data[ptr];
        wr_word.first <= start;
        wr_word.last  <= wr_eop[ptr];
        // header word carries its own fields, the rest repeat the latched ones
        wr_word.port  <= start ? wr_data[ptr][PORT_W-1:0] : hdr_port;
        wr_word.prio  <= start ? wr_data[ptr][PORT_W +: PRIO_W] : hdr_prio;
        if (!rst_n) begin
            wr_word.vld <= 1'b0;
        end else begin
            wr_word.vld <= take;
        end
    end

endmodule

/* rtl/packet_switch.sv */
module packet_switch
    import switch_pkg::*;
#(
    parameter int PORTS   = 4,
    parameter int DEPTH   = 64,
    parameter int MAX_PKT = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [PORTS-1:0]  wr_sop,
    input  logic [PORTS-1:0]  wr_eop,
    input  logic [PORTS-1:0]  wr_vld,
    input  data_t [PORTS-1:0] wr_data,
    output logic [PORTS-1:0]  pause,
    output logic              full,
    input  logic [PORTS-1:0]  ready,
    output logic [PORTS-1:0]  rd_sop,
    output logic [PORTS-1:0]  rd_vld,
    output logic [PORTS-1:0]  rd_eop,
    output data_t [PORTS-1:0] rd_data
);

    wr_word_t               wr_word;
    deq_req_t               deq_req;
    rd_word_t               rd_word;
    logic [PORTS*PRIOS-1:0] nonempty;

    // decode: write grant and header fields
    ingress_decode #(
        .PORTS(PORTS)
    ) ingress_decode_i (
        .clk(clk),
        .rst_n(rst_n),
        .wr_sop(wr_sop),
        .wr_vld(wr_vld),
        .wr_eop(wr_eop),
        .wr_data(wr_data),
        .full(full),
        .pause(pause),
        .wr_word(wr_word)
    );

    // execute: shared buffer and queues
    buffer_manager #(
        .PORTS(PORTS),
        .DEPTH(DEPTH),
        .MAX_PKT(MAX_PKT)
    ) buffer_manager_i (
        .clk(clk),
        .rst_n(rst_n),
        .wr_word(wr_word),
        .deq_req(deq_req),
        .rd_word(rd_word),
        .nonempty(nonempty),
        .full(full)
    );

    // result: output arbitration and framing
    egress_result #(
        .PORTS(PORTS)
    ) egress_result_i (
        .clk(clk),
        .rst_n(rst_n),
        .ready(ready),
        .nonempty(nonempty),
        .rd_word(rd_word),
        .deq_req(deq_req),
        .rd_sop(rd_sop),
        .rd_vld(rd_vld),
        .rd_eop(rd_eop),
        .rd_data(rd_data)
    );

endmodule

/* rtl/switch_pkg.sv */
package switch_pkg;

    // word and header field widths
    localparam int DATA_W = 16;
    localparam int PORT_W = 4;
    localparam int PRIO_W = 3;
    localparam int PRIOS  = 8;
    localparam int ADDR_W = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // one word from ingress into the shared buffer
    typedef struct packed {
        logic              vld;
        data_t             data;
        logic              first;
        logic              last;
        logic [PORT_W-1:0] port;
        logic [PRIO_W-1:0] prio;
    } wr_word_t;

    // single-cycle dequeue strobe from egress
    typedef struct packed {
        logic              vld;
        logic [PORT_W-1:0] port;
        logic [PRIO_W-1:0] prio;
    } deq_req_t;

    // one word streamed from the buffer towards egress
    typedef struct packed {
        logic  vld;
        data_t data;
        logic  last;
    } rd_word_t;

endpackage

/* testbench/packet_switch_props.sv */
module packet_switch_props #(
    parameter int PORTS = 4
) (
    input logic             clk,
    input logic             rst_n,
    input logic [PORTS-1:0] pause,
    input logic             full,
    input logic [PORTS-1:0] rd_sop
);

    // count of failed assertions, polled by the testbench
    int fail_cnt = 0;

    // write slot offered to one source at most
    one_slot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~pause))
        else begin
            $error("more than one pause bit low");
            fail_cnt++;
        end

    one_sop: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_sop))
        else begin
            $error("rd_sop on more than one port");
            fail_cnt++;
        end

    full_pauses: assert property (@(posedge clk) disable iff (!rst_n) full |=> &pause)
        else begin
            $error("source not paused after full");
            fail_cnt++;
        end

endmodule

bind packet_switch packet_switch_props #(
    .PORTS(PORTS)
) props_i (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .full(full),
    .rd_sop(rd_sop)
);

/* testbench/tb_packet_switch.sv */
module tb_packet_switch
    import switch_pkg::*;
();

    localparam int PORTS      = 4;
    localparam int DEPTH      = 64;
    localparam int MAX_PKT    = 16;
    // the longest test sequence takes a few thousand cycles
    localparam int MAX_CYCLES = 20000;

    logic              clk;
    logic              rst_n;
    logic [PORTS-1:0]  wr_sop;
    logic [PORTS-1:0]  wr_eop;
    logic [PORTS-1:0]  wr_vld;
    data_t [PORTS-1:0] wr_data;
    logic [PORTS-1:0]  ready;
    logic [PORTS-1:0]  pause;
    logic              full;
    logic [PORTS-1:0]  rd_sop;
    logic [PORTS-1:0]  rd_vld;
    logic [PORTS-1:0]  rd_eop;
    data_t [PORTS-1:0] rd_data;

    logic [31:0] lcg_state = 32'hc7e0;
    int          cycles;
    // words currently held in the shared buffer
    int          stored;

    // all packets built so far, words back to back
    data_t word_store[$];
    int    pkt_base[$];
    int    pkt_len[$];
    // expected delivery order per output and priority
    int    exp_q[PORTS*PRIOS][$];
    int    src_list[PORTS][$];

    packet_switch #(
        .PORTS(PORTS),
        .DEPTH(DEPTH),
        .MAX_PKT(MAX_PKT)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .wr_sop(wr_sop),
        .wr_eop(wr_eop),
        .wr_vld(wr_vld),
        .wr_data(wr_data),
        .pause(pause),
        .full(full),
        .ready(ready),
        .rd_sop(rd_sop),
        .rd_vld(rd_vld),
        .rd_eop(rd_eop),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'(r[30:16]) % (hi - lo + 1);
    endfunction

    // header carries dest in bits 3:0 and priority in bits 6:4
    function automatic int new_packet(input int dest, input int prio, input int len);
        logic [31:0] r;
        int          id;
        id = pkt_len.size();
        pkt_base.push_back(word_store.size());
        pkt_len.push_back(len);
        r = next_rand();
        word_store.push_back({r[24:16], PRIO_W'(prio), PORT_W'(dest)});
        for (int i = 1; i < len; i++) begin
            r = next_rand();
            word_store.push_back(r[31:16]);
        end
        return id;
    endfunction

    function automatic int queued_for(input int port);
        int n;
        n = 0;
        for (int k = 0; k < PRIOS; k++) begin
            n += exp_q[port*PRIOS + k].size();
        end
        return n;
    endfunction

    // strict priority, oldest first within one priority
    task automatic pop_expected(input int port, output int id);
        id = -1;
        for (int k = PRIOS - 1; k >= 0; k--) begin
            if (id < 0 && exp_q[port*PRIOS + k].size() > 0) begin
                id = exp_q[port*PRIOS + k].pop_front();
            end
        end
        if (id < 0) begin
            abort_run($sformatf("port %0d started a packet that was never queued for it", port));
        end
    endtask

    task automatic wait_enqueue();
        // a packet is queued 3 cycles after its eop
        repeat (4) @(posedge clk);
    endtask

    task automatic send_packet(input int src, input int id);
        int    prev;
        int    base;
        int    len;
        data_t hdr;
        prev = (src + PORTS - 1) % PORTS;
        base = pkt_base[id];
        len  = pkt_len[id];
        hdr  = word_store[base];
        // slot sits on the previous source and moves on unless it starts or full is set
        @(negedge clk);
        while (pause[prev] || (wr_sop[prev] && wr_vld[prev]) || full) begin
            @(negedge clk);
        end
        @(posedge clk);
        wr_sop[src]  <= 1'b1;
        wr_vld[src]  <= 1'b1;
        wr_eop[src]  <= 1'b0;
        wr_data[src] <= hdr;
        @(negedge clk);
        if (pause[src]) begin
            abort_run($sformatf("write slot did not open for source %0d", src));
        end
        exp_q[int'(hdr[PORT_W-1:0]) * PRIOS + int'(hdr[PORT_W +: PRIO_W])].push_back(id);
        stored += len;
        for (int i = 1; i < len; i++) begin
            @(posedge clk);
            wr_sop[src]  <= 1'b0;
            wr_eop[src]  <= (i == len - 1);
            wr_data[src] <= word_store[base + i];
        end
        @(posedge clk);
        wr_vld[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
    endtask

    task automatic send_batch(input int src);
        for (int i = 0; i < src_list[src].size(); i++) begin
            send_packet(src, src_list[src][i]);
        end
    endtask

    task automatic pulse_ready(input int port);
        @(posedge clk);
        ready[port] <= 1'b1;
        @(posedge clk);
        ready[port] <= 1'b0;
    endtask

    task automatic collect_packet(input int port, input string name);
        int id;
        int base;
        int len;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rd_sop[port]) begin
            waited++;
            if (waited > 2000) begin
                abort_run($sformatf("%s: no rd_sop on port %0d", name, port));
            end
            @(negedge clk);
        end
        pop_expected(port, id);
        base = pkt_base[id];
        len  = pkt_len[id];
        // one idle cycle between rd_sop and the first word
        @(negedge clk);
        check_flag({name, " rd_vld"}, 1'b0, rd_vld[port]);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            check_flag({name, " rd_vld"}, 1'b1, rd_vld[port]);
            check_word({name, " rd_data"}, word_store[base + i], rd_data[port]);
            check_flag({name, " rd_eop"}, i == len - 1, rd_eop[port]);
            check_flag({name, " other rd_vld"}, 1'b0, |(rd_vld & ~(PORTS'(1) << port)));
        end
        stored -= len;
    endtask

    task automatic receive_packet(input int port, input string name);
        pulse_ready(port);
        collect_packet(port, name);
    endtask

    task automatic after_reset();
        @(negedge clk);
        check_flag("after_reset rd_sop", 1'b0, |rd_sop);
        check_flag("after_reset rd_vld", 1'b0, |rd_vld);
        check_flag("after_reset rd_eop", 1'b0, |rd_eop);
        check_flag("after_reset full", 1'b0, full);
        check_flag("after_reset pause", 1'b1, &pause);
    endtask

    task automatic single_packet();
        int prio;
        int len;
        prio = rand_range(0, PRIOS - 1);
        len  = rand_range(2, MAX_PKT);
        send_packet(0, new_packet(2, prio, len));
        wait_enqueue();
        receive_packet(2, "single_packet");
    endtask

    task automatic strict_priority();
        int len;
        len = rand_range(2, MAX_PKT);
        send_packet(1, new_packet(0, 1, len));
        len = rand_range(2, MAX_PKT);
        send_packet(1, new_packet(0, 5, len));
        wait_enqueue();
        receive_packet(0, "strict_priority");
        receive_packet(0, "strict_priority");
        // equal priority keeps send order
        send_packet(3, new_packet(2, 4, 5));
        send_packet(3, new_packet(2, 4, 3));
        wait_enqueue();
        receive_packet(2, "equal_priority");
        receive_packet(2, "equal_priority");
    endtask

    task automatic mixed_traffic();
        int dest;
        int prio;
        int len;
        for (int r = 0; r < 4; r++) begin
            // at most 48 words per round, below the full threshold
            for (int s = 0; s < PORTS; s++) begin
                src_list[s].delete();
                for (int k = 0; k < 2; k++) begin
                    dest = rand_range(0, PORTS - 1);
                    prio = rand_range(0, PRIOS - 1);
                    len  = rand_range(2, 6);
                    src_list[s].push_back(new_packet(dest, prio, len));
                end
            end
            fork
                send_batch(0);
                send_batch(1);
                send_batch(2);
                send_batch(3);
            join
            wait_enqueue();
            for (int p = 0; p < PORTS; p++) begin
                while (queued_for(p) > 0) begin
                    receive_packet(p, "mixed_traffic");
                end
            end
        end
    endtask

    task automatic fill_and_drain();
        int prio;
        for (int i = 0; i < 7; i++) begin
            prio = rand_range(0, PRIOS - 1);
            send_packet(0, new_packet(3, prio, 8));
            wait_enqueue();
            check_flag("fill_and_drain full", stored > DEPTH - MAX_PKT, full);
        end
        repeat (10) begin
            @(negedge clk);
            check_flag("fill_and_drain pause", 1'b1, &pause);
        end
        for (int i = 0; i < 7; i++) begin
            receive_packet(3, "fill_and_drain");
        end
        wait_enqueue();
        check_flag("fill_and_drain full", 1'b0, full);
        send_packet(1, new_packet(3, 2, MAX_PKT));
        wait_enqueue();
        receive_packet(3, "fill_and_drain");
    endtask

    task automatic early_ready();
        int prio;
        int len;
        pulse_ready(1);
        repeat (10) begin
            @(negedge clk);
            check_flag("early_ready rd_sop", 1'b0, |rd_sop);
        end
        prio = rand_range(0, PRIOS - 1);
        len  = rand_range(2, MAX_PKT);
        send_packet(2, new_packet(1, prio, len));
        collect_packet(1, "early_ready");
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                abort_run("timeout, the tests did not finish within the cycle limit");
            end
            if (dut_i.props_i.fail_cnt != 0) begin
                abort_run("a bound assertion on the switch outputs failed");
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '0;
        stored  = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        single_packet();
        strict_priority();
        mixed_traffic();
        fill_and_drain();
        early_ready();
        repeat (5) @(posedge clk);
        if (dut_i.props_i.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion on the switch outputs failed");
        end
    end

endmodule

/* verilog.f */
rtl/switch_pkg.sv
rtl/ingress_decode.sv
rtl/buffer_manager.sv
rtl/egress_result.sv
rtl/packet_switch.sv
testbench/packet_switch_props.sv
testbench/tb_packet_switch.sv
